// ==== design/mem_access_pkg.sv ====
package mem_access_pkg;

    // width of one cpu data access.
    typedef enum logic [1:0] {
        acc_byte = 2'd0,
        acc_half = 2'd1,
        acc_word = 2'd2
    } acc_width_t;

    // one bit per cause, several may never be set together on this path.
    typedef logic [2:0] mem_exc_t;

    localparam int exc_ld_misalign = 0;
    localparam int exc_st_misalign = 1;
    localparam int exc_bus_err     = 2;

    // ram depth in 32-bit words.
    localparam int mem_words = 1024;

endpackage

// ==== design/axi_lite_pkg.sv ====
package axi_lite_pkg;

    typedef struct packed {
        logic [31:0] addr;
        logic [2:0]  size;
    } axi_addr_beat_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
    } axi_w_beat_t;

    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } axi_resp_t;

    // axsize encodings for 1, 2 and 4 bytes.
    localparam logic [2:0] axi_size_byte = 3'd0;
    localparam logic [2:0] axi_size_half = 3'd1;
    localparam logic [2:0] axi_size_word = 3'd2;

    localparam int fifo_depth = 2;

endpackage

// ==== design/axi_chan_fifo.sv ====
`timescale 1ns/1ps

module axi_chan_fifo #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_ready,
    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_ready
);
    import axi_lite_pkg::*;

    payload_t                          slots [fifo_depth];
    logic [$clog2(fifo_depth)-1:0]     wr_ptr, rd_ptr;
    logic [$clog2(fifo_depth+1)-1:0]   count;
    logic                              push, pop;

    assign in_ready  = (count != fifo_depth);
    assign out_valid = (count != 0);
    assign out_data  = slots[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            // simultaneous push and pop leaves the count alone.
            if (push && !pop) count <= count + 1'b1;
            else if (pop && !push) count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push) slots[wr_ptr] <= in_data;
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

// ==== design/lsu_uncached.sv ====
`timescale 1ns/1ps

module lsu_uncached (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         valid,
    input  logic                         op,
    input  logic [31:0]                  addr,
    input  logic [31:0]                  w_data,
    input  mem_access_pkg::acc_width_t   acc_width,
    input  logic                         load_unsigned,
    output logic                         ready,
    output logic                         data_valid,
    output logic [31:0]                  r_data,
    output mem_access_pkg::mem_exc_t     exc,
    output logic                         ar_valid,
    input  logic                         ar_ready,
    output axi_lite_pkg::axi_addr_beat_t ar_beat,
    output logic                         aw_valid,
    input  logic                         aw_ready,
    output axi_lite_pkg::axi_addr_beat_t aw_beat,
    output logic                         w_valid,
    input  logic                         w_ready,
    output axi_lite_pkg::axi_w_beat_t    w_beat,
    input  logic                         rvalid,
    input  logic [31:0]                  rdata,
    input  axi_lite_pkg::axi_resp_t      rresp,
    output logic                         rready,
    input  logic                         bvalid,
    input  axi_lite_pkg::axi_resp_t      bresp,
    output logic                         bready
);
    import mem_access_pkg::*;
    import axi_lite_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_issue,
        st_wait_r,
        st_wait_b,
        st_done
    } state_t;

    state_t      state, state_nx;
    logic        op_q, unsigned_q, resp_err_q;
    logic [31:0] addr_q, w_data_q, rdata_q, lane, wdata_lanes;
    acc_width_t  width_q;
    logic        misaligned, aw_sent, w_sent;
    logic [3:0]  strb;
    logic [2:0]  size_code;

    always_comb begin
        case (width_q)
            acc_half: misaligned = addr_q[0];
            acc_word: misaligned = |addr_q[1:0];
            default:  misaligned = 1'b0;
        endcase
    end

    // store lanes are replicated so the strobe alone picks the bytes.
    always_comb begin
        case (width_q)
            acc_byte: begin
                strb        = 4'b0001 << addr_q[1:0];
                wdata_lanes = {4{w_data_q[7:0]}};
                size_code   = axi_size_byte;
            end
            acc_half: begin
                strb        = 4'b0011 << {addr_q[1], 1'b0};
                wdata_lanes = {2{w_data_q[15:0]}};
                size_code   = axi_size_half;
            end
            default: begin
                strb        = 4'b1111;
                wdata_lanes = w_data_q;
                size_code   = axi_size_word;
            end
        endcase
    end

    assign ar_beat = '{addr: addr_q, size: size_code};
    assign aw_beat = '{addr: addr_q, size: size_code};
    assign w_beat  = '{data: wdata_lanes, strb: strb};

    assign ready    = (state == st_idle);
    assign ar_valid = (state == st_issue) && !misaligned && !op_q;
    assign aw_valid = (state == st_issue) && !misaligned && op_q && !aw_sent;
    assign w_valid  = (state == st_issue) && !misaligned && op_q && !w_sent;
    assign rready   = (state == st_wait_r);
    assign bready   = (state == st_wait_b);

    assign data_valid = ((state == st_issue) && misaligned) || (state == st_done);

    always_comb begin
        exc = '0;
        if ((state == st_issue) && misaligned)
            exc[op_q ? exc_st_misalign : exc_ld_misalign] = 1'b1;
        if ((state == st_done) && resp_err_q)
            exc[exc_bus_err] = 1'b1;
    end

    // load formatting.
    always_comb begin
        lane = rdata_q >> {addr_q[1:0], 3'b000};
        case (width_q)
            acc_byte: r_data = unsigned_q ? {24'b0, lane[7:0]} : {{24{lane[7]}}, lane[7:0]};
            acc_half: r_data = unsigned_q ? {16'b0, lane[15:0]} : {{16{lane[15]}}, lane[15:0]};
            default:  r_data = rdata_q;
        endcase
    end

    always_comb begin
        state_nx = state;
        case (state)
            st_idle:
                if (valid) state_nx = st_issue;
            st_issue:
                if (misaligned)
                    state_nx = st_idle;
                else if (!op_q && ar_ready)
                    state_nx = st_wait_r;
                else if (op_q && (aw_sent || aw_ready) && (w_sent || w_ready))
                    state_nx = st_wait_b;
            st_wait_r:
                if (rvalid) state_nx = st_done;
            st_wait_b:
                if (bvalid) state_nx = st_done;
            default:
                state_nx = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= st_idle;
            aw_sent <= 1'b0;
            w_sent  <= 1'b0;
        end else begin
            state <= state_nx;
            if (state == st_issue) begin
                if (aw_valid && aw_ready) aw_sent <= 1'b1;
                if (w_valid && w_ready) w_sent <= 1'b1;
            end else begin
                aw_sent <= 1'b0;
                w_sent  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (valid && ready) begin
            op_q       <= op;
            addr_q     <= addr;
            w_data_q   <= w_data;
            width_q    <= acc_width;
            unsigned_q <= load_unsigned;
        end
        if (rvalid && rready) begin
            rdata_q    <= rdata;
            resp_err_q <= (rresp == resp_slverr);
        end
        if (bvalid && bready)
            resp_err_q <= (bresp == resp_slverr);
    end

    // one request at a time means a new read or write never meets a response of the other kind.
    assert property (@(posedge clk) disable iff (!rst_n)
        !(ar_valid && aw_valid) && !(ar_valid && bvalid) && !(aw_valid && rvalid));

    assert property (@(posedge clk) disable iff (!rst_n) data_valid |=> !data_valid);

endmodule

// ==== design/axi_ram.sv ====
`timescale 1ns/1ps

module axi_ram (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         s_ar_valid,
    output logic                         s_ar_ready,
    input  axi_lite_pkg::axi_addr_beat_t s_ar_beat,
    output logic                         s_rvalid,
    input  logic                         s_rready,
    output logic [31:0]                  s_rdata,
    output axi_lite_pkg::axi_resp_t      s_rresp,
    input  logic                         s_aw_valid,
    output logic                         s_aw_ready,
    input  axi_lite_pkg::axi_addr_beat_t s_aw_beat,
    input  logic                         s_w_valid,
    output logic                         s_w_ready,
    input  axi_lite_pkg::axi_w_beat_t    s_w_beat,
    output logic                         s_bvalid,
    input  logic                         s_bready,
    output axi_lite_pkg::axi_resp_t      s_bresp
);
    import mem_access_pkg::*;
    import axi_lite_pkg::*;

    logic [31:0]  mem [mem_words];
    logic         ar_fire, aw_fire, w_fire, do_write;
    logic         ar_in_range, aw_in_range;
    logic         aw_held, w_held;
    logic [31:0]  aw_addr_q;
    axi_w_beat_t  w_beat_q;

    assign s_ar_ready = !s_rvalid;
    assign s_aw_ready = !aw_held;
    assign s_w_ready  = !w_held;

    assign ar_fire = s_ar_valid && s_ar_ready;
    assign aw_fire = s_aw_valid && s_aw_ready;
    assign w_fire  = s_w_valid && s_w_ready;

    assign ar_in_range = s_ar_beat.addr[31:2] < 30'(mem_words);
    assign aw_in_range = aw_addr_q[31:2] < 30'(mem_words);

    // a write goes ahead once both halves are here and b is free.
    assign do_write = aw_held && w_held && !s_bvalid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s_rvalid <= 1'b0;
            s_bvalid <= 1'b0;
            aw_held  <= 1'b0;
            w_held   <= 1'b0;
        end else begin
            if (ar_fire) s_rvalid <= 1'b1;
            else if (s_rready) s_rvalid <= 1'b0;

            if (do_write) s_bvalid <= 1'b1;
            else if (s_bready) s_bvalid <= 1'b0;

            if (aw_fire) aw_held <= 1'b1;
            else if (do_write) aw_held <= 1'b0;

            if (w_fire) w_held <= 1'b1;
            else if (do_write) w_held <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire) aw_addr_q <= s_aw_beat.addr;
        if (w_fire) w_beat_q <= s_w_beat;
        if (ar_fire) begin
            if (ar_in_range) begin
                s_rdata <= mem[s_ar_beat.addr[$clog2(mem_words)+1:2]];
                s_rresp <= resp_okay;
            end else begin
                s_rdata <= '0;
                s_rresp <= resp_slverr;
            end
        end
        if (do_write) s_bresp <= aw_in_range ? resp_okay : resp_slverr;
    end

    // out of range writes are dropped.
    always_ff @(posedge clk) begin
        if (do_write && aw_in_range) begin
            for (int i = 0; i < 4; i++) begin
                if (w_beat_q.strb[i])
                    mem[aw_addr_q[$clog2(mem_words)+1:2]][8*i +: 8] <= w_beat_q.data[8*i +: 8];
            end
        end
    end

endmodule

// ==== design/data_mem.sv ====
`timescale 1ns/1ps

module data_mem (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       valid,
    input  logic                       op,
    input  logic [31:0]                addr,
    input  logic [31:0]                w_data,
    input  mem_access_pkg::acc_width_t acc_width,
    input  logic                       load_unsigned,
    output logic                       ready,
    output logic                       data_valid,
    output logic [31:0]                r_data,
    output mem_access_pkg::mem_exc_t   exc
);
    import axi_lite_pkg::*;

    // unit to fifo side.
    logic           lsu_ar_valid, lsu_ar_ready, lsu_aw_valid, lsu_aw_ready;
    logic           lsu_w_valid, lsu_w_ready;
    axi_addr_beat_t lsu_ar_beat, lsu_aw_beat;
    axi_w_beat_t    lsu_w_beat;

    // fifo to ram side.
    logic           ram_ar_valid, ram_ar_ready, ram_aw_valid, ram_aw_ready;
    logic           ram_w_valid, ram_w_ready;
    axi_addr_beat_t ram_ar_beat, ram_aw_beat;
    axi_w_beat_t    ram_w_beat;

    logic           rvalid, rready, bvalid, bready;
    logic [31:0]    rdata;
    axi_resp_t      rresp, bresp;

    lsu_uncached lsu_i (
        .clk(clk), .rst_n(rst_n), .valid(valid), .op(op), .addr(addr),
        .w_data(w_data), .acc_width(acc_width), .load_unsigned(load_unsigned),
        .ready(ready), .data_valid(data_valid), .r_data(r_data), .exc(exc),
        .ar_valid(lsu_ar_valid), .ar_ready(lsu_ar_ready), .ar_beat(lsu_ar_beat),
        .aw_valid(lsu_aw_valid), .aw_ready(lsu_aw_ready), .aw_beat(lsu_aw_beat),
        .w_valid(lsu_w_valid), .w_ready(lsu_w_ready), .w_beat(lsu_w_beat),
        .rvalid(rvalid), .rdata(rdata), .rresp(rresp), .rready(rready),
        .bvalid(bvalid), .bresp(bresp), .bready(bready)
    );

    axi_chan_fifo #(.payload_t(axi_addr_beat_t)) ar_fifo (
        .clk(clk), .rst_n(rst_n),
        .in_valid(lsu_ar_valid), .in_data(lsu_ar_beat), .in_ready(lsu_ar_ready),
        .out_valid(ram_ar_valid), .out_data(ram_ar_beat), .out_ready(ram_ar_ready)
    );

    axi_chan_fifo #(.payload_t(axi_addr_beat_t)) aw_fifo (
        .clk(clk), .rst_n(rst_n),
        .in_valid(lsu_aw_valid), .in_data(lsu_aw_beat), .in_ready(lsu_aw_ready),
        .out_valid(ram_aw_valid), .out_data(ram_aw_beat), .out_ready(ram_aw_ready)
    );

    axi_chan_fifo #(.payload_t(axi_w_beat_t)) w_fifo (
        .clk(clk), .rst_n(rst_n),
        .in_valid(lsu_w_valid), .in_data(lsu_w_beat), .in_ready(lsu_w_ready),
        .out_valid(ram_w_valid), .out_data(ram_w_beat), .out_ready(ram_w_ready)
    );

    axi_ram ram_i (
        .clk(clk), .rst_n(rst_n),
        .s_ar_valid(ram_ar_valid), .s_ar_ready(ram_ar_ready), .s_ar_beat(ram_ar_beat),
        .s_rvalid(rvalid), .s_rready(rready), .s_rdata(rdata), .s_rresp(rresp),
        .s_aw_valid(ram_aw_valid), .s_aw_ready(ram_aw_ready), .s_aw_beat(ram_aw_beat),
        .s_w_valid(ram_w_valid), .s_w_ready(ram_w_ready), .s_w_beat(ram_w_beat),
        .s_bvalid(bvalid), .s_bready(bready), .s_bresp(bresp)
    );

endmodule

// ==== sim/clk_gen.sv ====
`timescale 1ns/1ps

module clk_gen #(
    parameter int period       = 10,
    parameter int reset_cycles = 3
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // release just after an edge so no flop sees reset change at the edge.
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

// ==== sim/tb_data_mem.sv ====
`timescale 1ns/1ps

module tb_data_mem;
    import mem_access_pkg::*;

    localparam int clk_period = 10;
    localparam int mem_bytes  = mem_words * 4;
    // fill 1024 + readback 64 + merge 30 + misaligned 7 + range 6 + random 300.
    localparam int total_ops  = 1431;
    localparam int timeout_ns = (total_ops * 30 + 200) * clk_period;

    logic        clk, rst_n;
    logic        valid, op, load_unsigned;
    logic [31:0] addr, w_data, r_data;
    acc_width_t  acc_width;
    logic        ready, data_valid;
    mem_exc_t    exc;

    logic [7:0]  model_mem [mem_bytes];
    int          seed = 32'hc897f87e;
    int          check_count = 0;
    int          err_count = 0;

    clk_gen #(.period(clk_period), .reset_cycles(3)) clk_gen_i (.clk(clk), .rst_n(rst_n));

    data_mem dut_i (
        .clk(clk), .rst_n(rst_n), .valid(valid), .op(op), .addr(addr),
        .w_data(w_data), .acc_width(acc_width), .load_unsigned(load_unsigned),
        .ready(ready), .data_valid(data_valid), .r_data(r_data), .exc(exc)
    );

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            err_count++;
            $display("Fail %s: expected %h, got %h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_count == errs_before)
            $display("test %s: pass", name);
        else
            $display("test %s: %0d mismatches", name, err_count - errs_before);
    endtask

    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return (a * 32'h9e3779b1) ^ 32'h5bd1e995;
    endfunction

    function automatic logic [31:0] align_addr(input logic [31:0] a, input acc_width_t w);
        case (w)
            acc_half: return a & 32'hffff_fffe;
            acc_word: return a & 32'hffff_fffc;
            default:  return a;
        endcase
    endfunction

    // misalignment wins over range, since nothing reaches the bus.
    function automatic mem_exc_t expect_exc(input logic st, input logic [31:0] a,
                                            input acc_width_t w);
        mem_exc_t e;
        logic     mis;
        e = '0;
        case (w)
            acc_half: mis = a[0];
            acc_word: mis = (a[1:0] != 2'b00);
            default:  mis = 1'b0;
        endcase
        if (mis) begin
            if (st)
                e[exc_st_misalign] = 1'b1;
            else
                e[exc_ld_misalign] = 1'b1;
        end else if (a >= mem_bytes) begin
            e[exc_bus_err] = 1'b1;
        end
        return e;
    endfunction

    function automatic logic [31:0] expect_load(input logic [31:0] a, input acc_width_t w,
                                                input logic uns);
        logic [11:0] i;
        logic [7:0]  b0, b1;
        i = a[11:0];
        if (a >= mem_bytes)
            return 32'h0;
        b0 = model_mem[i];
        b1 = model_mem[i + 12'd1];
        case (w)
            acc_byte: return uns ? {24'h0, b0} : {{24{b0[7]}}, b0};
            acc_half: return uns ? {16'h0, b1, b0} : {{16{b1[7]}}, b1, b0};
            default:  return {model_mem[i + 12'd3], model_mem[i + 12'd2], b1, b0};
        endcase
    endfunction

    task automatic model_store(input logic [31:0] a, input logic [31:0] d, input acc_width_t w);
        logic [11:0] i;
        i = a[11:0];
        model_mem[i] = d[7:0];
        if (w != acc_byte)
            model_mem[i + 12'd1] = d[15:8];
        if (w == acc_word) begin
            model_mem[i + 12'd2] = d[23:16];
            model_mem[i + 12'd3] = d[31:24];
        end
    endtask

    // one request from handshake to completion, checked against the model.
    task automatic run_op(input logic st, input logic [31:0] a, input logic [31:0] d,
                          input acc_width_t w, input logic uns);
        mem_exc_t    exp_exc;
        logic [31:0] exp_data;
        exp_exc  = expect_exc(st, a, w);
        exp_data = expect_load(a, w, uns);
        while (!ready) begin
            @(posedge clk);
            #1;
        end
        valid         = 1'b1;
        op            = st;
        addr          = a;
        w_data        = d;
        acc_width     = w;
        load_unsigned = uns;
        @(posedge clk);
        #1;
        valid = 1'b0;
        while (!data_valid) begin
            @(posedge clk);
            #1;
        end
        check_value("exc", 32'(exp_exc), 32'(exc));
        if (!st && (exp_exc == 3'b000 || exp_exc[exc_bus_err]))
            check_value("r_data", exp_data, r_data);
        if (st && exp_exc == 3'b000)
            model_store(a, d, w);
    endtask

    task automatic run_random_ops(input int n);
        logic [31:0] r, ra, rd, a;
        acc_width_t  w;
        for (int k = 0; k < n; k++) begin
            r  = $random(seed);
            ra = $random(seed);
            rd = $random(seed);
            case (r[3:2])
                2'd0:    w = acc_byte;
                2'd1:    w = acc_half;
                default: w = acc_word;
            endcase
            case (r[7:5])
                3'd0:    a = 32'h1000 + {20'b0, ra[11:0]};
                3'd1:    a = ra;
                default: a = {20'b0, ra[11:0]};
            endcase
            // most accesses are aligned so they reach the ram.
            if (r[9:8] != 2'b00)
                a = align_addr(a, w);
            run_op(r[0], a, rd, w, r[4]);
        end
    endtask

    initial begin
        int errs_before;
        valid         = 1'b0;
        op            = 1'b0;
        addr          = 32'h0;
        w_data        = 32'h0;
        acc_width     = acc_word;
        load_unsigned = 1'b0;
        wait (rst_n === 1'b1);
        @(posedge clk);
        #1;

        errs_before = err_count;
        check_value("ready", 32'h1, 32'(ready));
        check_value("data_valid", 32'h0, 32'(data_valid));
        check_value("exc", 32'h0, 32'(exc));
        report_test("reset state", errs_before);

        errs_before = err_count;
        for (int k = 0; k < mem_words; k++)
            run_op(1'b1, 32'(k * 4), fill_word(32'(k * 4)), acc_word, 1'b0);
        for (int k = 0; k < 64; k++)
            run_op(1'b0, 32'(k * 64), 32'h0, acc_word, 1'b0);
        report_test("word store and load", errs_before);

        errs_before = err_count;
        run_op(1'b1, 32'h301, 32'h0000_00a5, acc_byte, 1'b0);
        run_op(1'b1, 32'h302, 32'hffff_80fe, acc_half, 1'b0);
        run_op(1'b1, 32'h304, 32'h1234_567f, acc_byte, 1'b0);
        run_op(1'b1, 32'h306, 32'h0000_1234, acc_half, 1'b0);
        run_op(1'b0, 32'h300, 32'h0, acc_word, 1'b0);
        run_op(1'b0, 32'h304, 32'h0, acc_word, 1'b0);
        for (int b = 0; b < 8; b++) begin
            run_op(1'b0, 32'h300 + 32'(b), 32'h0, acc_byte, 1'b0);
            run_op(1'b0, 32'h300 + 32'(b), 32'h0, acc_byte, 1'b1);
        end
        for (int b = 0; b < 4; b++) begin
            run_op(1'b0, 32'h300 + 32'(b * 2), 32'h0, acc_half, 1'b0);
            run_op(1'b0, 32'h300 + 32'(b * 2), 32'h0, acc_half, 1'b1);
        end
        report_test("byte and half merge", errs_before);

        errs_before = err_count;
        run_op(1'b1, 32'h201, 32'hdead_beef, acc_half, 1'b0);
        run_op(1'b1, 32'h202, 32'hdead_beef, acc_word, 1'b0);
        run_op(1'b1, 32'h203, 32'hdead_beef, acc_word, 1'b0);
        run_op(1'b0, 32'h201, 32'h0, acc_word, 1'b0);
        run_op(1'b0, 32'h203, 32'h0, acc_half, 1'b1);
        run_op(1'b0, 32'h200, 32'h0, acc_word, 1'b0);
        run_op(1'b0, 32'h204, 32'h0, acc_word, 1'b0);
        report_test("misaligned access", errs_before);

        errs_before = err_count;
        run_op(1'b1, 32'h1000, 32'hcafe_f00d, acc_word, 1'b0);
        run_op(1'b0, 32'h1000, 32'h0, acc_word, 1'b0);
        run_op(1'b0, 32'h1003, 32'h0, acc_byte, 1'b0);
        run_op(1'b1, 32'h2000, 32'h0000_8181, acc_half, 1'b0);
        run_op(1'b0, 32'hffff_fffc, 32'h0, acc_word, 1'b0);
        // the dropped write must not alias onto word 0.
        run_op(1'b0, 32'h0, 32'h0, acc_word, 1'b0);
        report_test("out of range", errs_before);

        errs_before = err_count;
        run_random_ops(300);
        report_test("random operations", errs_before);

        $display("checks %0d, mismatches %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        #(timeout_ns);
        $display("run timed out after %0d ns waiting for the DUT", timeout_ns);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// ==== verilog.f ====
design/mem_access_pkg.sv
design/axi_lite_pkg.sv
design/axi_chan_fifo.sv
design/lsu_uncached.sv
design/axi_ram.sv
design/data_mem.sv
sim/clk_gen.sv
sim/tb_data_mem.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_data_mem -f verilog.f -o tb_data_mem &&
./obj_dir/tb_data_mem | tee /dev/stderr | grep -q "NO ERRORS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
